// File: hdl/audio_pkg.sv
// shared types, clock constants and register map for the audio playback subsystem
package audio_pkg;

    typedef logic [15:0] word_t;        // host and sample memory data word
    typedef logic [15:0] addr_t;        // sample word address
    typedef logic [7:0]  byte_t;        // unsigned DAC input

    // volume register as written by the host and as used by the mixer
    typedef union packed {
        word_t raw;                     // host view
        struct packed {
            logic signed [7:0] left;    // high byte
            logic signed [7:0] right;   // low byte
        } pan;
    } vol_t;

    localparam int PCLK_HZ       = 25_175_000;  // pixel clock
    localparam int AUDIO_BASE_HZ = 48_000;      // base rate tick

    localparam logic [2:0] REG_VOL       = 3'd0;
    localparam logic [2:0] REG_RATE      = 3'd1;
    localparam logic [2:0] REG_START     = 3'd2;
    localparam logic [2:0] REG_LEN       = 3'd3;
    localparam logic [2:0] REG_CTRL      = 3'd4;
    localparam logic [2:0] REG_ADDR_STAT = 3'd5;    // read only
    localparam logic [2:0] REG_LEN_STAT  = 3'd6;    // read only

    localparam int RAM_DEPTH = 256;     // sample memory words

endpackage

// File: hdl/audio_chan_if.sv
// channel settings from the register file and playback status from the mixer
`timescale 1ns/1ps

interface aud_chan_if import audio_pkg::*; ();

    vol_t        vol;           // left/right volume
    word_t       rate;          // rate reload value, bits 14:0 used
    addr_t       start;         // sample start word address
    logic [14:0] len;           // sample length in words
    logic        enable;        // channel on

    addr_t       cur_addr;      // current sample word address
    logic [15:0] cur_len;       // remaining byte count

    modport regs (
        output vol, rate, start, len, enable,
        input  cur_addr, cur_len
    );

    modport mixer (
        input  vol, rate, start, len, enable,
        output cur_addr, cur_len
    );

endinterface

// File: hdl/audio_regs.sv
// host register file holding channel settings, with registered readback of settings and status
`timescale 1ns/1ps

module audio_regs import audio_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       reg_wr_i,
    input  logic [2:0] reg_addr_i,
    input  word_t      reg_data_i,
    output word_t      reg_rdata_o,
    aud_chan_if.regs   chan
);

    vol_t        vol;
    word_t       rate;
    addr_t       start;
    logic [14:0] len;
    logic        enable;

    assign chan.vol    = vol;
    assign chan.rate   = rate;
    assign chan.start  = start;
    assign chan.len    = len;
    assign chan.enable = enable;

    // host write decode
    always_ff @(posedge clk) begin
        if (reset_i) begin
            vol    <= '0;
            rate   <= '0;
            start  <= '0;
            len    <= '0;
            enable <= 1'b0;
        end else if (reg_wr_i) begin
            case (reg_addr_i)
                REG_VOL:   vol.raw <= reg_data_i;
                REG_RATE:  rate    <= reg_data_i;
                REG_START: start   <= reg_data_i;
                REG_LEN:   len     <= reg_data_i[14:0];
                REG_CTRL:  enable  <= reg_data_i[0];    // only bit 0 is kept
                default: ;                              // status is read only
            endcase
        end
    end

    // readback is one cycle behind the address
    always_ff @(posedge clk) begin
        if (reset_i) begin
            reg_rdata_o <= '0;
        end else begin
            case (reg_addr_i)
                REG_VOL:       reg_rdata_o <= vol.raw;
                REG_RATE:      reg_rdata_o <= rate;
                REG_START:     reg_rdata_o <= start;
                REG_LEN:       reg_rdata_o <= {1'b0, len};
                REG_CTRL:      reg_rdata_o <= {15'b0, enable};
                REG_ADDR_STAT: reg_rdata_o <= chan.cur_addr;   // live playback address
                REG_LEN_STAT:  reg_rdata_o <= chan.cur_len;    // bytes left
                default:       reg_rdata_o <= '0;
            endcase
        end
    end

endmodule

// File: hdl/audio_sample_ram.sv
// sample word memory with a host write port and a fetch enabled read port for the mixer
`timescale 1ns/1ps

module audio_sample_ram import audio_pkg::*; (
    input  logic  clk,
    input  logic  ram_wr_i,
    input  addr_t ram_addr_i,
    input  word_t ram_data_i,
    input  logic  fetch_i,
    input  addr_t fetch_addr_i,
    output word_t sample_word_o
);

    word_t mem [RAM_DEPTH];     // two signed samples per word

    // host write port
    always_ff @(posedge clk) begin
        if (ram_wr_i) begin
            mem[ram_addr_i[$clog2(RAM_DEPTH)-1:0]] <= ram_data_i;
        end
    end

    // read port holds its word between fetches
    always_ff @(posedge clk) begin
        if (fetch_i) begin
            sample_word_o <= mem[fetch_addr_i[$clog2(RAM_DEPTH)-1:0]];
        end
    end

endmodule

// File: hdl/audio_mixer.sv
// single channel mixer with rate timer, playback FSM, sample counters and volume scaling
`timescale 1ns/1ps

module audio_mixer import audio_pkg::*; (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      mix_strobe_i,
    aud_chan_if.mixer chan,
    output logic      fetch_o,
    output addr_t     fetch_addr_o,
    input  word_t     sample_word_i,
    output byte_t     output_l_o,
    output byte_t     output_r_o
);

    enum logic [1:0] {
        IDLE = 2'b00,
        MIX  = 2'b01,
        RATE = 2'b10,
        INCR = 2'b11
    } mix_state;

    logic [27:0]        timer;          // fractional accumulator, sign bit marks wait
    logic               tick;           // base rate tick
    word_t              rate_count;     // bit 15 set means next sample is due
    logic [16:0]        byte_count;     // bit 16 is the underflow flag
    addr_t              addr;
    logic               fetch;

    logic signed [7:0]  samp;           // latched sample byte
    logic signed [7:0]  vol_l;
    logic signed [7:0]  vol_r;
    logic signed [15:0] prod_l;
    logic signed [15:0] prod_r;

    assign fetch_o      = fetch;
    assign fetch_addr_o = addr;

    assign chan.cur_addr = addr;
    assign chan.cur_len  = byte_count[15:0];

    assign tick = ~timer[27];

    // fractional divider from pixel clock down to the base rate
    always_ff @(posedge clk) begin
        if (reset_i) begin
            timer <= '0;
        end else begin
            timer <= timer + (timer[27] ? 28'(AUDIO_BASE_HZ)
                                        : 28'(AUDIO_BASE_HZ - PCLK_HZ));
        end
    end

    assign prod_l = samp * vol_l;
    assign prod_r = samp * vol_r;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mix_state  <= IDLE;
            rate_count <= '0;
            byte_count <= '0;
            addr       <= '0;
            fetch      <= 1'b0;
            samp       <= '0;
            vol_l      <= '0;
            vol_r      <= '0;
            output_l_o <= '0;
            output_r_o <= '0;
        end else begin
            if (tick) begin
                rate_count <= rate_count - 1'b1;
            end

            if (!chan.enable) begin
                output_l_o <= '0;               // silent, FSM holds
                output_r_o <= '0;
            end else begin
                case (mix_state)
                    IDLE: begin
                        if (mix_strobe_i) begin
                            samp  <= byte_count[0] ? sample_word_i[15:8]
                                                   : sample_word_i[7:0];
                            vol_l <= chan.vol.pan.left;
                            vol_r <= chan.vol.pan.right;
                            mix_state <= MIX;
                        end
                    end
                    MIX: begin
                        output_l_o <= prod_l[13:6] + 8'h80;    // offset to unsigned
                        output_r_o <= prod_r[13:6] + 8'h80;
                        mix_state  <= RATE;
                    end
                    RATE: begin
                        fetch      <= 1'b0;
                        rate_count <= {1'b0, chan.rate[14:0]};
                        if (rate_count[15]) begin       // next sample due
                            byte_count <= byte_count - 1'b1;
                            mix_state  <= INCR;
                        end else begin
                            mix_state  <= IDLE;
                        end
                    end
                    INCR: begin
                        if (!byte_count[0]) begin
                            addr <= addr + 1'b1;        // both bytes of the word used
                        end
                        if (byte_count[16]) begin       // loop back to start
                            addr       <= chan.start;
                            byte_count <= {1'b0, chan.len, 1'b0};
                        end
                        fetch     <= 1'b1;
                        mix_state <= IDLE;
                    end
                    default: mix_state <= IDLE;
                endcase
            end
        end
    end

endmodule

// File: hdl/audio_dac.sv
// first order sigma-delta PDM modulator, one per audio output
`timescale 1ns/1ps

module audio_dac #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             reset_i,
    input  logic [WIDTH-1:0] value_i,
    output logic             pulse_o
);

    logic [WIDTH-1:0] acc;
    logic [WIDTH:0]   sum;      // carry in the top bit

    assign sum = {1'b0, acc} + {1'b0, value_i};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            acc     <= '0;
            pulse_o <= 1'b0;
        end else begin
            acc     <= sum[WIDTH-1:0];
            pulse_o <= sum[WIDTH];  // density follows value_i / 2**WIDTH
        end
    end

endmodule

// File: hdl/audio_subsys.sv
// top level of the audio playback subsystem, joins registers, sample memory, mixer and DACs
`timescale 1ns/1ps

module audio_subsys import audio_pkg::*; (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       mix_strobe_i,
    input  logic       reg_wr_i,
    input  logic [2:0] reg_addr_i,
    input  word_t      reg_data_i,
    output word_t      reg_rdata_o,
    input  logic       ram_wr_i,
    input  addr_t      ram_addr_i,
    input  word_t      ram_data_i,
    output logic       pdm_l_o,
    output logic       pdm_r_o
);

    logic  fetch;
    addr_t fetch_addr;
    word_t sample_word;
    byte_t output_l;
    byte_t output_r;

    aud_chan_if chan_if ();

    audio_regs audio_regs_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .reg_wr_i    (reg_wr_i),
        .reg_addr_i  (reg_addr_i),
        .reg_data_i  (reg_data_i),
        .reg_rdata_o (reg_rdata_o),
        .chan        (chan_if.regs)
    );

    audio_sample_ram audio_sample_ram_inst (
        .clk           (clk),
        .ram_wr_i      (ram_wr_i),
        .ram_addr_i    (ram_addr_i),
        .ram_data_i    (ram_data_i),
        .fetch_i       (fetch),
        .fetch_addr_i  (fetch_addr),
        .sample_word_o (sample_word)
    );

    audio_mixer audio_mixer_inst (
        .clk           (clk),
        .reset_i       (reset_i),
        .mix_strobe_i  (mix_strobe_i),
        .chan          (chan_if.mixer),
        .fetch_o       (fetch),
        .fetch_addr_o  (fetch_addr),
        .sample_word_i (sample_word),
        .output_l_o    (output_l),
        .output_r_o    (output_r)
    );

    audio_dac #(.WIDTH(8)) audio_dac_l_inst (
        .clk     (clk),
        .reset_i (reset_i),
        .value_i (output_l),
        .pulse_o (pdm_l_o)
    );

    audio_dac #(.WIDTH(8)) audio_dac_r_inst (
        .clk     (clk),
        .reset_i (reset_i),
        .value_i (output_r),
        .pulse_o (pdm_r_o)
    );

endmodule

// File: tb/audio_subsys_tb.sv
// testbench for the audio subsystem, programs it randomly and checks PDM density and status
`timescale 1ns/1ps

module audio_subsys_tb import audio_pkg::*; ();

    localparam int GAP             = 600;               // cycles between mix strobes
    localparam int STROBES         = 1 + 4 + 6 + 20;    // worst case over all tests
    localparam int WATCHDOG_CYCLES = STROBES * GAP + 5000;

    logic       clk          = 1'b0;
    logic       reset_i      = 1'b1;
    logic       mix_strobe_i = 1'b0;
    logic       reg_wr_i     = 1'b0;
    logic [2:0] reg_addr_i   = '0;
    word_t      reg_data_i   = '0;
    word_t      reg_rdata_o;
    logic       ram_wr_i     = 1'b0;
    addr_t      ram_addr_i   = '0;
    word_t      ram_data_i   = '0;
    logic       pdm_l_o;
    logic       pdm_r_o;

    logic [31:0] lfsr = 32'hbf59;
    word_t       mem_model [RAM_DEPTH];
    word_t       m_vol;
    word_t       m_rate;
    word_t       m_word;            // word held on the memory read port
    addr_t       m_start;
    addr_t       m_addr;
    logic [14:0] m_len;
    logic [16:0] m_bytes;           // bit 16 flags underflow
    logic        m_enable;
    logic        m_fetch = 1'b0;
    logic        m_due;             // rate counter negative at the next pass
    int          errors      = 0;
    int          checks      = 0;
    int          test_errors = 0;

    audio_subsys audio_subsys_inst (.*);

    always #10 clk = ~clk;

    function automatic word_t random_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic byte_t mix_level(input logic [7:0] samp, input logic [7:0] vol);
        logic signed [15:0] prod;
        prod = $signed(samp) * $signed(vol);
        return prod[13:6] + 8'h80;      // offset to unsigned
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, expected);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_test(input string name);
        if (test_errors == 0)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset_i <= 1'b1;
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;
        if (m_fetch)
            m_word = mem_model[m_addr[7:0]];    // read port keeps its last word
        m_fetch  = 1'b0;
        m_due    = 1'b1;                        // first tick wraps the counter negative
        m_bytes  = '0;
        m_addr   = '0;
        m_vol    = '0;
        m_rate   = '0;
        m_start  = '0;
        m_len    = '0;
        m_enable = 1'b0;
    endtask

    task automatic write_reg(input logic [2:0] addr, input word_t data);
        @(posedge clk);
        reg_wr_i   <= 1'b1;
        reg_addr_i <= addr;
        reg_data_i <= data;
        @(posedge clk);
        reg_wr_i   <= 1'b0;
        case (addr)
            REG_VOL:   m_vol    = data;
            REG_RATE:  m_rate   = data;
            REG_START: m_start  = data;
            REG_LEN:   m_len    = data[14:0];
            REG_CTRL:  m_enable = data[0];
            default: ;
        endcase
    endtask

    task automatic read_reg(input logic [2:0] addr, output word_t data);
        @(posedge clk);
        reg_addr_i <= addr;
        @(posedge clk);
        @(negedge clk);
        data = reg_rdata_o;                     // registered one cycle after the address
    endtask

    task automatic fill_memory();
        word_t data;
        for (int i = 0; i < RAM_DEPTH; i++) begin
            data         = random_bits(16);
            mem_model[i] = data;
            @(posedge clk);
            ram_wr_i   <= 1'b1;
            ram_addr_i <= addr_t'(i);
            ram_data_i <= data;
        end
        @(posedge clk);
        ram_wr_i <= 1'b0;
    endtask

    task automatic count_ones(output int ones_l, output int ones_r);
        ones_l = 0;
        ones_r = 0;
        repeat (256) begin
            @(negedge clk);
            ones_l += (pdm_l_o === 1'b1);
            ones_r += (pdm_r_o === 1'b1);
        end
    endtask

    // one mix strobe, PDM window and status readback, 600 cycles in all
    task automatic run_pass(input logic check_out);
        word_t      word;
        logic [7:0] samp;
        byte_t      exp_l;
        byte_t      exp_r;
        int         ones_l;
        int         ones_r;
        word_t      rd;
        exp_l = '0;
        exp_r = '0;
        if (m_enable) begin
            word    = m_fetch ? mem_model[m_addr[7:0]] : m_word;
            samp    = m_bytes[0] ? word[15:8] : word[7:0];  // odd count plays the high byte
            exp_l   = mix_level(samp, m_vol[15:8]);
            exp_r   = mix_level(samp, m_vol[7:0]);
            m_word  = word;
            m_fetch = 1'b0;
            if (m_due) begin
                m_bytes = m_bytes - 1'b1;
                if (!m_bytes[0])
                    m_addr = m_addr + 1'b1;
                if (m_bytes[16]) begin                      // loop back to start
                    m_addr  = m_start;
                    m_bytes = {1'b0, m_len, 1'b0};
                end
                m_fetch = 1'b1;
            end
            m_due = (m_rate[14:0] == 15'd0);    // zero rate is due again within 600 cycles
        end
        @(posedge clk);
        mix_strobe_i <= 1'b1;
        @(posedge clk);
        mix_strobe_i <= 1'b0;
        repeat (2) @(posedge clk);              // output is stable from here on
        count_ones(ones_l, ones_r);
        if (check_out) begin
            check_value("pdm_l_o ones", ones_l, exp_l);
            check_value("pdm_r_o ones", ones_r, exp_r);
        end
        read_reg(REG_ADDR_STAT, rd);
        check_value("cur_addr", rd, m_addr);
        read_reg(REG_LEN_STAT, rd);
        check_value("cur_len", rd, m_bytes[15:0]);
        repeat (GAP - 263) @(posedge clk);
    endtask

    initial begin
        word_t rd;
        word_t vals [5];
        int    ones_l;
        int    ones_r;
        int    passes;
        apply_reset();
        for (int i = 0; i <= 6; i++) begin
            read_reg(3'(i), rd);
            check_value($sformatf("reg %0d", i), rd, 0);
        end
        count_ones(ones_l, ones_r);
        check_value("pdm_l_o ones", ones_l, 0);
        check_value("pdm_r_o ones", ones_r, 0);
        report_test("reset state");

        fill_memory();
        for (int i = 0; i < 5; i++) begin
            vals[i] = random_bits(16);
            write_reg(3'(i), vals[i]);
        end
        for (int i = 0; i < 5; i++) begin
            read_reg(3'(i), rd);
            check_value($sformatf("reg %0d", i), rd,
                        vals[i] & ((i == 3) ? 16'h7fff : (i == 4) ? 16'h0001 : 16'hffff));
        end
        write_reg(REG_CTRL, 16'h0001);
        run_pass(1'b0);                         // sample word is still unknown here
        report_test("register readback");

        apply_reset();
        fill_memory();
        for (int i = 0; i < 4; i++)
            write_reg(3'(i), random_bits(16));
        write_reg(REG_CTRL, random_bits(16) & 16'hfffe);
        repeat (4) run_pass(1'b1);
        report_test("disabled output");

        apply_reset();
        fill_memory();
        write_reg(REG_RATE, 16'h7fff);          // playback stays put after the first reload
        write_reg(REG_START, random_bits(8));
        write_reg(REG_LEN, random_bits(15));
        write_reg(REG_CTRL, 16'h0001);
        repeat (6) begin
            write_reg(REG_VOL, random_bits(16));
            run_pass(1'b1);
        end
        report_test("volume and pan");

        apply_reset();
        fill_memory();
        write_reg(REG_VOL, random_bits(16));
        write_reg(REG_RATE, 16'h0000);
        write_reg(REG_START, random_bits(16));
        write_reg(REG_LEN, random_bits(2) + 16'd1);
        write_reg(REG_CTRL, 16'h0001);
        passes = 2 * (2 * m_len + 1) + 2;       // reload pass plus two whole loops
        repeat (passes) run_pass(1'b1);
        report_test("playback and looping");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: audio_subsys.f
hdl/audio_pkg.sv
hdl/audio_chan_if.sv
hdl/audio_regs.sv
hdl/audio_sample_ram.sv
hdl/audio_mixer.sv
hdl/audio_dac.sv
hdl/audio_subsys.sv
tb/audio_subsys_tb.sv
